/* tpu_pkg.sv */
package tpu_pkg;

    // Element and accumulator widths
    localparam int DATA_W = 8;
    localparam int ACC_W  = 20;   // 4 products of 8x8 plus headroom

    // Activation limits for the output byte
    localparam int ACT_MIN = 0;
    localparam int ACT_MAX = 2**(DATA_W-1) - 1;

    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // Which buffer a load beat goes to
    typedef enum logic {
        OP_LOAD_FEATURE = 1'b0,
        OP_LOAD_WEIGHT  = 1'b1
    } opcode_e;

    // Host load stream payload
    typedef struct packed {
        opcode_e op;
        data_t   data;
    } load_beat_t;

    // Operand moving through the systolic grid
    typedef struct packed {
        logic  valid;
        data_t data;
    } operand_t;

    // Run phases of the feeder
    typedef enum logic [1:0] {
        PH_IDLE   = 2'd0,
        PH_FEED   = 2'd1,
        PH_SETTLE = 2'd2,
        PH_DRAIN  = 2'd3
    } phase_e;

endpackage

/* mac_cell.sv */
`timescale 1ns/1ps

module mac_cell (
    input  logic              clk,
    input  logic              rst,
    input  logic              clear,
    input  tpu_pkg::operand_t west_in,
    input  tpu_pkg::operand_t north_in,
    output tpu_pkg::operand_t east_out,
    output tpu_pkg::operand_t south_out,
    output tpu_pkg::acc_t     acc
);
    import tpu_pkg::*;

    logic signed [2*DATA_W-1:0] product;
    logic                       both_valid;

    assign product    = west_in.data * north_in.data;
    assign both_valid = west_in.valid && north_in.valid;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            acc <= '0;
        end else if (both_valid) begin
            acc <= acc + acc_t'(product);   // Sign-extended product
        end
    end

    // Operands move one hop per cycle
    always_ff @(posedge clk) begin
        east_out  <= west_in;
        south_out <= north_in;
        if (rst) begin
            east_out.valid  <= 1'b0;
            south_out.valid <= 1'b0;
        end
    end

    // Feeder skew must line up both operand streams at every cell
    assert property (@(posedge clk) disable iff (rst)
        west_in.valid == north_in.valid)
        else $error("mac_cell: west and north operands misaligned");

endmodule

/* matrix_buffer.sv */
`timescale 1ns/1ps

module matrix_buffer #(
    parameter int N = 4
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           load_valid,
    output logic                           load_ready,
    input  tpu_pkg::load_beat_t            load_beat,
    input  logic                           busy,
    input  logic [$clog2(N)-1:0]           step,
    output tpu_pkg::data_t [N-1:0]         a_col,
    output tpu_pkg::data_t [N-1:0]         w_row
);
    import tpu_pkg::*;

    localparam int DEPTH = N * N;
    localparam int IDX_W = $clog2(DEPTH);

    data_t feat_mem [DEPTH];    // Matrix A in row-major order
    data_t wgt_mem  [DEPTH];    // Matrix W in row-major order

    logic [IDX_W-1:0] feat_idx;
    logic [IDX_W-1:0] wgt_idx;
    logic             load_fire;
    logic             is_weight;

    // Write index wraps back to element 0 after a full matrix
    function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
        if (idx == IDX_W'(DEPTH - 1)) begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

    assign load_ready = !busy;                  // No loads while a run reads the buffers
    assign load_fire  = load_valid && load_ready;
    assign is_weight  = (load_beat.op == OP_LOAD_WEIGHT);

    always_ff @(posedge clk) begin
        if (load_fire) begin
            if (is_weight) begin
                wgt_mem[wgt_idx] <= load_beat.data;
            end else begin
                feat_mem[feat_idx] <= load_beat.data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            feat_idx <= '0;
            wgt_idx  <= '0;
        end else if (load_fire) begin
            if (is_weight) begin
                wgt_idx <= next_idx(wgt_idx);
            end else begin
                feat_idx <= next_idx(feat_idx);
            end
        end
    end

    // Column k of A goes west and row k of W goes north
    always_comb begin
        for (int r = 0; r < N; r++) begin
            a_col[r] = feat_mem[r*N + int'(step)];
            w_row[r] = wgt_mem[int'(step)*N + r];
        end
    end

    // The feeder walks the columns in order at one per cycle
    assert property (@(posedge clk) disable iff (rst)
        step != '0 |-> busy && step == $past(step) + 1'b1)
        else $error("matrix_buffer: step out of sequence");

endmodule

/* skew_feeder.sv */
`timescale 1ns/1ps

module skew_feeder #(
    parameter int N = 4
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start_valid,
    output logic                           start_ready,
    output logic                           busy,
    output logic [$clog2(N)-1:0]           step,
    input  tpu_pkg::data_t [N-1:0]         a_col,
    input  tpu_pkg::data_t [N-1:0]         w_row,
    output tpu_pkg::operand_t [N-1:0]      west_in,
    output tpu_pkg::operand_t [N-1:0]      north_in,
    output logic                           clear,
    output logic                           grid_done,
    input  logic                           drain_done
);
    import tpu_pkg::*;

    localparam int STEP_W        = $clog2(N);
    localparam int FEED_CYCLES   = N + 2*(N-1);   // Steps plus skew through the grid
    localparam int SETTLE_CYCLES = 2;
    localparam int CNT_W         = $clog2(FEED_CYCLES + 1);

    phase_e           phase;
    logic [CNT_W-1:0] cnt;
    logic             feed_valid;

    assign start_ready = (phase == PH_IDLE);
    assign busy        = (phase != PH_IDLE);
    assign feed_valid  = (phase == PH_FEED) && (cnt < CNT_W'(N));
    assign step        = feed_valid ? cnt[STEP_W-1:0] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase     <= PH_IDLE;
            cnt       <= '0;
            clear     <= 1'b0;
            grid_done <= 1'b0;
        end else begin
            clear     <= 1'b0;
            grid_done <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (start_valid) begin
                        phase <= PH_FEED;
                        cnt   <= '0;
                        clear <= 1'b1;      // Zero accumulators before first product
                    end
                end
                PH_FEED: begin
                    if (cnt == CNT_W'(FEED_CYCLES - 1)) begin
                        phase <= PH_SETTLE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                PH_SETTLE: begin
                    if (cnt == CNT_W'(SETTLE_CYCLES - 1)) begin
                        phase     <= PH_DRAIN;
                        cnt       <= '0;
                        grid_done <= 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                PH_DRAIN: if (drain_done) phase <= PH_IDLE;   // Last result taken
                default:  phase <= PH_IDLE;
            endcase
        end
    end

    // Row i and column i share the same delay depth of i+1 registers
    for (genvar i = 0; i < N; i++) begin : g_skew
        operand_t west_pipe  [i+1];
        operand_t north_pipe [i+1];

        always_ff @(posedge clk) begin
            west_pipe[0]  <= '{valid: feed_valid, data: a_col[i]};
            north_pipe[0] <= '{valid: feed_valid, data: w_row[i]};
            for (int d = 1; d <= i; d++) begin
                west_pipe[d]  <= west_pipe[d-1];
                north_pipe[d] <= north_pipe[d-1];
            end
            if (rst) begin
                for (int d = 0; d <= i; d++) begin
                    west_pipe[d].valid  <= 1'b0;
                    north_pipe[d].valid <= 1'b0;
                end
            end
        end

        assign west_in[i]  = west_pipe[i];
        assign north_in[i] = north_pipe[i];
    end

    // The drain can only finish a run that handed it results
    assert property (@(posedge clk) disable iff (rst)
        drain_done |-> phase == PH_DRAIN)
        else $error("skew_feeder: drain_done outside the drain phase");

endmodule

/* result_drain.sv */
`timescale 1ns/1ps

module result_drain #(
    parameter int N = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          grid_done,
    input  tpu_pkg::acc_t [N*N-1:0]       grid_acc,
    output logic                          out_valid,
    input  logic                          out_ready,
    output tpu_pkg::data_t                out_data,
    output logic                          out_last,
    output logic                          drain_done
);
    import tpu_pkg::*;

    localparam int COUNT = N * N;
    localparam int IDX_W = $clog2(COUNT);

    data_t            res_buf [COUNT];
    logic [IDX_W-1:0] idx;          // Row-major read position
    logic             out_fire;

    // Clip negatives to zero, saturate at the top of the byte
    function automatic data_t activate(input acc_t v);
        if (v < acc_t'(ACT_MIN)) begin
            return data_t'(ACT_MIN);
        end else if (v > acc_t'(ACT_MAX)) begin
            return data_t'(ACT_MAX);
        end
        return v[DATA_W-1:0];
    endfunction

    always_ff @(posedge clk) begin
        if (grid_done) begin
            for (int e = 0; e < COUNT; e++) begin
                res_buf[e] <= activate(grid_acc[e]);
            end
        end
    end

    assign out_fire   = out_valid && out_ready;
    assign out_data   = res_buf[idx];
    assign out_last   = out_valid && (idx == IDX_W'(COUNT - 1));
    assign drain_done = out_fire && out_last;    // Feeder may go idle

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            idx       <= '0;
        end else if (grid_done) begin
            out_valid <= 1'b1;      // Same edge as the capture
            idx       <= '0;
        end else if (out_fire) begin
            if (out_last) begin
                out_valid <= 1'b0;
                idx       <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // Stalled beat must not change under the host
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("result_drain: output changed while stalled");

endmodule

/* tpu_top.sv */
`timescale 1ns/1ps

module tpu_top #(
    parameter int N = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                load_valid,
    output logic                load_ready,
    input  tpu_pkg::load_beat_t load_beat,
    input  logic                start_valid,
    output logic                start_ready,
    output logic                out_valid,
    input  logic                out_ready,
    output tpu_pkg::data_t      out_data,
    output logic                out_last
);
    import tpu_pkg::*;

    logic                   busy;
    logic [$clog2(N)-1:0]   step;
    data_t    [N-1:0]       a_col;
    data_t    [N-1:0]       w_row;
    operand_t [N-1:0]       west_in;
    operand_t [N-1:0]       north_in;
    logic                   clear;
    logic                   grid_done;
    logic                   drain_done;
    acc_t     [N*N-1:0]     grid_acc;     // Row-major, i*N + j

    operand_t east_bus  [N][N];
    operand_t south_bus [N][N];

    matrix_buffer #(.N(N)) u_buffer (
        .clk        (clk),
        .rst        (rst),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .load_beat  (load_beat),
        .busy       (busy),
        .step       (step),
        .a_col      (a_col),
        .w_row      (w_row)
    );

    skew_feeder #(.N(N)) u_feeder (
        .clk         (clk),
        .rst         (rst),
        .start_valid (start_valid),
        .start_ready (start_ready),
        .busy        (busy),
        .step        (step),
        .a_col       (a_col),
        .w_row       (w_row),
        .west_in     (west_in),
        .north_in    (north_in),
        .clear       (clear),
        .grid_done   (grid_done),
        .drain_done  (drain_done)
    );

    for (genvar i = 0; i < N; i++) begin : g_row
        for (genvar j = 0; j < N; j++) begin : g_col
            operand_t cell_w;
            operand_t cell_n;

            // Edge cells take their operands straight from the feeder
            if (j == 0) begin : g_w_edge
                assign cell_w = west_in[i];
            end else begin : g_w_int
                assign cell_w = east_bus[i][j-1];
            end
            if (i == 0) begin : g_n_edge
                assign cell_n = north_in[j];
            end else begin : g_n_int
                assign cell_n = south_bus[i-1][j];
            end

            mac_cell u_cell (
                .clk       (clk),
                .rst       (rst),
                .clear     (clear),
                .west_in   (cell_w),
                .north_in  (cell_n),
                .east_out  (east_bus[i][j]),
                .south_out (south_bus[i][j]),
                .acc       (grid_acc[i*N + j])
            );
        end
    end

    result_drain #(.N(N)) u_drain (
        .clk        (clk),
        .rst        (rst),
        .grid_done  (grid_done),
        .grid_acc   (grid_acc),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .out_last   (out_last),
        .drain_done (drain_done)
    );

endmodule

/* tb_tpu.sv */
`timescale 1ns/1ps

module tb_tpu;
    import tpu_pkg::*;

    localparam int N               = 4;
    localparam int COUNT           = N * N;
    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 8;
    localparam int SEED            = 32'h0149_9150;
    localparam int TEST_COUNT      = 6;
    localparam int WAIT_LIMIT      = 4 * COUNT;        // Bound on any single handshake wait
    localparam int COLLECT_LIMIT   = 64 * COUNT;
    localparam int WATCHDOG_CYCLES = TEST_COUNT * (2*N*N + 3*N + 1 + 64) * 4 + 500;

    logic       clk = 1'b0;
    logic       rst;
    logic       load_valid;
    logic       load_ready;
    load_beat_t load_beat;
    logic       start_valid;
    logic       start_ready;
    logic       out_valid;
    logic       out_ready;
    data_t      out_data;
    logic       out_last;

    int          a_mat [COUNT];       // Row-major A
    int          w_mat [COUNT];       // Row-major W
    int          got_data [COUNT];
    bit          got_last [COUNT];
    int          err_count;
    int          chk_count;
    int          test_num;

    tpu_top #(.N(N)) DUT (
        .clk         (clk),
        .rst         (rst),
        .load_valid  (load_valid),
        .load_ready  (load_ready),
        .load_beat   (load_beat),
        .start_valid (start_valid),
        .start_ready (start_ready),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data),
        .out_last    (out_last)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    task automatic check(input string msg, input int got, input int expected);
        chk_count++;
        if (got !== expected) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, msg, got, expected);
            err_count++;
        end
    endtask

    // Sum of A[i][k]*W[k][j] clipped to 0..127
    function automatic int clipped_product(input int i, input int j);
        int sum;
        sum = 0;
        for (int k = 0; k < N; k++) begin
            sum += a_mat[i*N + k] * w_mat[k*N + j];
        end
        if (sum < 0) begin
            return 0;
        end
        if (sum > 127) begin
            return 127;
        end
        return sum;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;     // Drive point after the edge
    endtask

    task automatic send_beat(input opcode_e op, input int value);
        bit accepted;
        int waited;
        load_valid     = 1'b1;
        load_beat.op   = op;
        load_beat.data = data_t'(value);
        accepted       = 1'b0;
        waited         = 0;
        while (!accepted && waited < WAIT_LIMIT) begin
            accepted = load_ready;      // Transfer happens on the coming edge
            next_cycle();
            waited++;
        end
        load_valid = 1'b0;
        if (!accepted) begin
            $display("ERROR: load beat was never accepted");
            err_count++;
        end
    endtask

    task automatic load_matrices(input bit do_a, input bit do_w);
        if (do_a) begin
            for (int e = 0; e < COUNT; e++) begin
                send_beat(OP_LOAD_FEATURE, a_mat[e]);
            end
        end
        if (do_w) begin
            for (int e = 0; e < COUNT; e++) begin
                send_beat(OP_LOAD_WEIGHT, w_mat[e]);
            end
        end
    endtask

    task automatic start_run(input bit poke_load);
        bit accepted;
        int waited;
        start_valid = 1'b1;
        accepted    = 1'b0;
        waited      = 0;
        while (!accepted && waited < WAIT_LIMIT) begin
            accepted = start_ready;
            next_cycle();
            waited++;
        end
        start_valid = 1'b0;
        if (!accepted) begin
            $display("ERROR: start command was never accepted");
            err_count++;
        end
        if (poke_load) begin
            load_valid = 1'b1;          // Must be refused while busy
            load_beat  = '{op: OP_LOAD_FEATURE, data: data_t'(99)};
        end
        waited = 0;
        while (!out_valid && waited < WAIT_LIMIT) begin
            check("load_ready while computing", load_ready, 0);
            check("start_ready while computing", start_ready, 0);
            next_cycle();
            waited++;
        end
        load_valid = 1'b0;
        if (!out_valid) begin
            $display("ERROR: out_valid never rose after the start command");
            err_count++;
        end
    endtask

    task automatic collect_results(input bit random_ready);
        int    beats;
        int    cycles;
        bit    stalled;
        data_t held;
        beats   = 0;
        cycles  = 0;
        stalled = 1'b0;
        held    = '0;
        while (beats < COUNT && cycles < COLLECT_LIMIT) begin
            out_ready = random_ready ? ($urandom_range(1, 0) == 1) : 1'b1;
            check("load_ready while draining", load_ready, 0);
            check("start_ready while draining", start_ready, 0);
            if (stalled) begin
                check($sformatf("out_data held at beat %0d", beats), out_data, held);
            end
            if (out_valid && out_ready) begin
                got_data[beats] = out_data;
                got_last[beats] = out_last;
                beats++;
                stalled = 1'b0;
            end else if (out_valid) begin
                stalled = 1'b1;
                held    = out_data;
            end else begin
                $display("ERROR: out_valid dropped after %0d of %0d beats", beats, COUNT);
                err_count++;
            end
            next_cycle();
            cycles++;
        end
        out_ready = 1'b0;
        if (beats < COUNT) begin
            $display("ERROR: only %0d of %0d result beats arrived", beats, COUNT);
            err_count++;
        end
        check("out_valid after the last beat", out_valid, 0);   // No extra beats
    endtask

    task automatic compare_results(input string label);
        for (int e = 0; e < COUNT; e++) begin
            check($sformatf("%s C[%0d][%0d]", label, e / N, e % N),
                  got_data[e], clipped_product(e / N, e % N));
            check($sformatf("%s out_last at beat %0d", label, e), got_last[e], e == COUNT-1);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_num++;
        $display("Test %0d %s done, %0d errors", test_num, name, err_count - errs_before);
    endtask

    task automatic test_reset_state();
        int errs;
        errs = err_count;
        check("load_ready after reset", load_ready, 1);
        check("start_ready after reset", start_ready, 1);
        check("out_valid after reset", out_valid, 0);
        check("out_last after reset", out_last, 0);
        report_test("reset_state", errs);
    endtask

    task automatic test_identity();
        int errs;
        errs = err_count;
        for (int e = 0; e < COUNT; e++) begin
            a_mat[e] = int'($urandom_range(255, 0)) - 128;
            w_mat[e] = (e / N == e % N) ? 1 : 0;
        end
        load_matrices(1'b1, 1'b1);
        start_run(1'b0);
        collect_results(1'b0);
        for (int e = 0; e < COUNT; e++) begin
            check($sformatf("identity C[%0d][%0d]", e / N, e % N),
                  got_data[e], (a_mat[e] > 0) ? a_mat[e] : 0);
            check($sformatf("identity out_last at beat %0d", e), got_last[e], e == COUNT-1);
        end
        report_test("identity", errs);
    endtask

    task automatic test_random();
        int errs;
        errs = err_count;
        for (int e = 0; e < COUNT; e++) begin
            a_mat[e] = int'($urandom_range(16, 0)) - 8;
            w_mat[e] = int'($urandom_range(16, 0)) - 8;
        end
        load_matrices(1'b1, 1'b1);
        start_run(1'b0);
        collect_results(1'b0);
        compare_results("random");
        report_test("random", errs);
    endtask

    task automatic test_clipping();
        int errs;
        errs = err_count;
        for (int e = 0; e < COUNT; e++) begin
            a_mat[e] = (e / N < 2) ? 120 : -120;     // Top rows positive and bottom rows negative
            if (e % N == N-1) begin
                w_mat[e] = (e / N == 0) ? 1 : 0;     // Last column passes A[i][0] through
            end else begin
                w_mat[e] = 120;
            end
        end
        load_matrices(1'b1, 1'b1);
        start_run(1'b0);
        collect_results(1'b0);
        compare_results("clipping");
        report_test("clipping", errs);
    endtask

    task automatic test_backpressure();
        int errs;
        errs = err_count;
        for (int e = 0; e < COUNT; e++) begin
            a_mat[e] = int'($urandom_range(40, 0)) - 20;
            w_mat[e] = int'($urandom_range(16, 0)) - 8;
        end
        load_matrices(1'b1, 1'b1);
        start_run(1'b0);
        collect_results(1'b1);
        compare_results("backpressure");
        report_test("backpressure", errs);
    endtask

    task automatic test_reload();
        int errs;
        errs = err_count;
        for (int e = 0; e < COUNT; e++) begin
            a_mat[e] = int'($urandom_range(16, 0)) - 8;
            w_mat[e] = int'($urandom_range(16, 0)) - 8;
        end
        load_matrices(1'b1, 1'b1);
        start_run(1'b1);            // Load attempt during the run
        collect_results(1'b1);
        compare_results("reload first");
        check("load_ready after the run", load_ready, 1);
        check("start_ready after the run", start_ready, 1);
        // Only W is reloaded and A stays in the buffer
        for (int e = 0; e < COUNT; e++) begin
            w_mat[e] = int'($urandom_range(16, 0)) - 8;
        end
        load_matrices(1'b0, 1'b1);
        start_run(1'b0);
        collect_results(1'b0);
        compare_results("reload second");
        report_test("reload", errs);
    endtask

    initial begin
        void'($urandom(SEED));
        err_count   = 0;
        chk_count   = 0;
        test_num    = 0;
        rst         = 1'b1;
        load_valid  = 1'b0;
        load_beat   = '0;
        start_valid = 1'b0;
        out_ready   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        test_reset_state();
        test_identity();
        test_random();
        test_clipping();
        test_backpressure();
        test_reload();

        $display("Summary: %0d tests, %0d checks, %0d errors", test_num, chk_count, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* src.f */
tpu_pkg.sv
mac_cell.sv
matrix_buffer.sv
skew_feeder.sv
result_drain.sv
tpu_top.sv
tb_tpu.sv

/* Bender.yml */
package:
  name: tpu_systolic

sources:
  - tpu_pkg.sv
  - mac_cell.sv
  - matrix_buffer.sv
  - skew_feeder.sv
  - result_drain.sv
  - tpu_top.sv
  - target: test
    files:
      - tb_tpu.sv
